//--- wconv_settings.svh
// width converter settings
`ifndef WCONV_SETTINGS_SVH
`define WCONV_SETTINGS_SVH

// ------------------------------------------------------------
// data path widths
// ------------------------------------------------------------
`define WCONV_SDATA_W 64 // slave side, wide
`define WCONV_MDATA_W 32 // master side, narrow

// byte-address bits inside one master word
`define WCONV_MBYTE_W 2

// ------------------------------------------------------------
// queue sizes
// ------------------------------------------------------------
`define WCONV_CMD_DEPTH_LOG2 2  // four outstanding commands
`define WCONV_BEAT_DEPTH_LOG2 2 // four master beats

// stop stepping at two queued beats, leaves room for two in flight
`define WCONV_BEAT_PFULL 2

`endif

//--- wconv_pkg.sv
// width converter types
`include "wconv_settings.svh"

package wconv_pkg;

    // controller FSM
    typedef enum logic [1:0] {
        IDLE = 2'b00, // wait for a queued command
        LOAD = 2'b01, // one cycle, preload address and counters
        WAIT = 2'b10  // stepping through master beats
    } ctrl_state_e;

    // ------------------------------------------------------------
    // per-burst command, 22 bits
    // ------------------------------------------------------------
    typedef struct packed {
        logic [2:0] reqsize; // log2 bytes per master beat
        logic [2:0] size;    // log2 master beats per slave beat
        logic [7:0] len;     // master beats minus one
        logic [7:0] offset;  // starting byte address
    } split_cmd_t;

    // wide beat from the slave side
    typedef struct packed {
        logic [`WCONV_SDATA_W-1:0]   data;
        logic [`WCONV_SDATA_W/8-1:0] strb;
    } s_beat_t;

    // narrow beat to the master side
    typedef struct packed {
        logic [`WCONV_MDATA_W-1:0]   data;
        logic [`WCONV_MDATA_W/8-1:0] strb;
        logic                        last; // final beat of the command
    } m_beat_t;

endpackage

//--- sync_fifo.sv
// single-clock show-ahead FIFO
`timescale 1ns/100ps

module sync_fifo #(
    parameter int WIDTH       = 32,
    parameter int DEPTH_LOG2  = 2,
    parameter int PFULL_LEVEL = 2
) (
    input  logic             clk_sys,
    input  logic             rst_n,
    input  logic             wr_en,
    input  logic [WIDTH-1:0] wr_data,
    input  logic             rd_en,
    output logic [WIDTH-1:0] rd_data,
    output logic             empty,
    output logic             pfull
);

    localparam int                  DEPTH     = 1 << DEPTH_LOG2;
    localparam logic [DEPTH_LOG2:0] FULL_CNT  = {1'b1, {DEPTH_LOG2{1'b0}}};
    localparam logic [DEPTH_LOG2:0] PFULL_CNT = PFULL_LEVEL[DEPTH_LOG2:0];

    logic [WIDTH-1:0]      mem [DEPTH];
    logic [DEPTH_LOG2-1:0] wr_ptr;
    logic [DEPTH_LOG2-1:0] rd_ptr;
    logic [DEPTH_LOG2:0]   count; // one extra bit to tell full from empty
    logic                  full;
    logic                  wr_ok;
    logic                  rd_ok;

    assign full  = (count == FULL_CNT);
    assign empty = (count == '0);
    assign pfull = (count >= PFULL_CNT);

    // overflow and underflow are dropped
    assign wr_ok = wr_en && !full;
    assign rd_ok = rd_en && !empty;

    // ------------------------------------------------------------
    // pointers and occupancy
    // ------------------------------------------------------------
    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_ok) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_ok) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr_ok, rd_ok})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count; // both or neither
            endcase
        end
    end

    // storage
    always_ff @(posedge clk_sys) begin
        if (wr_ok) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    // head entry always on the read port
    assign rd_data = mem[rd_ptr];

endmodule

//--- split_ctrl.sv
// split controller for the downsizing path
`timescale 1ns/100ps

module split_ctrl (
    input  logic                  clk_sys,
    input  logic                  rst_n,
    input  wconv_pkg::split_cmd_t cmd,
    input  logic                  cmd_empty,
    input  logic                  s_valid,
    input  logic                  beat_pfull,
    output logic                  cmd_pop,
    output logic                  s_ready,
    output logic                  load,
    output logic                  advance,
    output logic                  last
);

    import wconv_pkg::*;

    ctrl_state_e state;
    ctrl_state_e nstate;

    logic [7:0] mlen_cnt; // master beat index within the command
    logic [7:0] stp_cnt;  // master beats taken from the current slave beat
    logic [7:0] stp_max;  // beats per slave beat minus one
    logic       step;
    logic       last_beat;
    logic       stp_done;

    // ------------------------------------------------------------
    // step qualification
    // ------------------------------------------------------------
    assign step      = (state == WAIT) && s_valid && !beat_pfull;
    assign stp_max   = (8'd1 << cmd.size) - 8'd1;
    assign last_beat = (mlen_cnt == cmd.len);
    assign stp_done  = (stp_cnt == stp_max);

    // ------------------------------------------------------------
    // state machine
    // ------------------------------------------------------------
    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= nstate;
        end
    end

    always_comb begin
        nstate = state;
        case (state)
            IDLE: begin
                if (!cmd_empty) begin
                    nstate = LOAD;
                end
            end
            LOAD: nstate = WAIT;
            WAIT: begin
                if (step && last_beat) begin
                    nstate = IDLE; // command finished
                end
            end
            default: nstate = IDLE;
        endcase
    end

    // ------------------------------------------------------------
    // counters
    // ------------------------------------------------------------
    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            mlen_cnt <= '0;
        end else if (state == LOAD) begin
            mlen_cnt <= '0;
        end else if (step) begin
            mlen_cnt <= mlen_cnt + 8'd1;
        end
    end

    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            stp_cnt <= '0;
        end else if (state == LOAD) begin
            stp_cnt <= '0;
        end else if (step) begin
            // wrap on a slave beat boundary or the end of the command
            if (stp_done || last_beat) begin
                stp_cnt <= '0;
            end else begin
                stp_cnt <= stp_cnt + 8'd1;
            end
        end
    end

    // ------------------------------------------------------------
    // outputs
    // ------------------------------------------------------------
    assign load    = (state == LOAD);
    assign advance = step;
    assign last    = (state == WAIT) && last_beat;
    assign cmd_pop = step && last_beat;

    // release the slave beat early on the final master beat
    assign s_ready = step && (stp_done || last_beat);

endmodule

//--- lane_mux.sv
// lane selection and beat FIFO write
`timescale 1ns/100ps
`include "wconv_settings.svh"

module lane_mux (
    input  logic                  clk_sys,
    input  logic                  rst_n,
    input  wconv_pkg::split_cmd_t cmd,
    input  logic                  load,
    input  logic                  advance,
    input  logic                  last,
    input  wconv_pkg::s_beat_t    s_beat,
    output logic                  wr_en,
    output wconv_pkg::m_beat_t    wr_beat
);

    import wconv_pkg::*;

    localparam int MDATA_W = `WCONV_MDATA_W;
    localparam int MSTRB_W = `WCONV_MDATA_W / 8;
    localparam int SUB_W   = $clog2(`WCONV_SDATA_W / `WCONV_MDATA_W);

    logic [7:0]       byte_addr; // running byte address of the next master beat
    logic [SUB_W-1:0] lane;
    m_beat_t          sel_beat;

    // ------------------------------------------------------------
    // byte address tracking
    // ------------------------------------------------------------
    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            byte_addr <= '0;
        end else if (load) begin
            byte_addr <= cmd.offset;
        end else if (advance) begin
            byte_addr <= byte_addr + (8'd1 << cmd.reqsize);
        end
    end

    // sub-word index sits just above the master byte bits
    assign lane = byte_addr[`WCONV_MBYTE_W +: SUB_W];

    always_comb begin
        sel_beat.data = s_beat.data[lane * MDATA_W +: MDATA_W];
        sel_beat.strb = s_beat.strb[lane * MSTRB_W +: MSTRB_W];
        sel_beat.last = last;
    end

    // ------------------------------------------------------------
    // registered write into the beat FIFO
    // ------------------------------------------------------------
    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            wr_en <= 1'b0;
        end else begin
            wr_en <= advance; // one write per step
        end
    end

    always_ff @(posedge clk_sys) begin
        if (advance) begin
            wr_beat <= sel_beat;
        end
    end

endmodule

//--- wconv_top.sv
// AXI write-data width converter, 64 to 32 bits
`timescale 1ns/100ps
`include "wconv_settings.svh"

module wconv_top (
    input  logic                  clk_sys,
    input  logic                  rst_n,
    input  logic                  split_en,
    input  wconv_pkg::split_cmd_t split_cmd,
    input  logic                  s_valid,
    input  wconv_pkg::s_beat_t    s_beat,
    output logic                  s_ready,
    output logic                  m_valid,
    output wconv_pkg::m_beat_t    m_beat,
    input  logic                  m_ready
);

    import wconv_pkg::*;

    split_cmd_t cmd_head;
    logic       cmd_empty;
    logic       cmd_pop;
    logic       load;
    logic       advance;
    logic       last;
    logic       wr_en;
    m_beat_t    wr_beat;
    logic       beat_pfull;
    logic       beat_empty;

    // ------------------------------------------------------------
    // command queue
    // ------------------------------------------------------------
    sync_fifo #(
        .WIDTH       ($bits(split_cmd_t)),
        .DEPTH_LOG2  (`WCONV_CMD_DEPTH_LOG2),
        .PFULL_LEVEL (1 << `WCONV_CMD_DEPTH_LOG2)
    ) u_cmd_fifo (
        .clk_sys (clk_sys),
        .rst_n   (rst_n),
        .wr_en   (split_en),
        .wr_data (split_cmd),
        .rd_en   (cmd_pop),
        .rd_data (cmd_head),
        .empty   (cmd_empty),
        .pfull   () // caller keeps within the depth
    );

    split_ctrl u_split_ctrl (
        .clk_sys    (clk_sys),
        .rst_n      (rst_n),
        .cmd        (cmd_head),
        .cmd_empty  (cmd_empty),
        .s_valid    (s_valid),
        .beat_pfull (beat_pfull),
        .cmd_pop    (cmd_pop),
        .s_ready    (s_ready),
        .load       (load),
        .advance    (advance),
        .last       (last)
    );

    lane_mux u_lane_mux (
        .clk_sys (clk_sys),
        .rst_n   (rst_n),
        .cmd     (cmd_head),
        .load    (load),
        .advance (advance),
        .last    (last),
        .s_beat  (s_beat),
        .wr_en   (wr_en),
        .wr_beat (wr_beat)
    );

    // ------------------------------------------------------------
    // master beat queue, almost-full throttles the controller
    // ------------------------------------------------------------
    sync_fifo #(
        .WIDTH       ($bits(m_beat_t)),
        .DEPTH_LOG2  (`WCONV_BEAT_DEPTH_LOG2),
        .PFULL_LEVEL (`WCONV_BEAT_PFULL)
    ) u_beat_fifo (
        .clk_sys (clk_sys),
        .rst_n   (rst_n),
        .wr_en   (wr_en),
        .wr_data (wr_beat),
        .rd_en   (m_valid && m_ready),
        .rd_data (m_beat),
        .empty   (beat_empty),
        .pfull   (beat_pfull)
    );

    assign m_valid = !beat_empty;

endmodule

//--- tb_wconv.sv
// width converter testbench
`timescale 1ns/100ps

module tb_wconv;

    import wconv_pkg::*;

    localparam int          TIMEOUT_CYCLES = 200;
    localparam logic [31:0] LFSR_SEED      = 32'ha9d7_04ed;

    logic        clk_sys;
    logic        rst_n;
    logic        split_en;
    split_cmd_t  split_cmd;
    logic        s_valid;
    s_beat_t     s_beat;
    logic        s_ready;
    logic        m_valid;
    m_beat_t     m_beat;
    logic        m_ready;

    split_cmd_t  cmd_q[$];
    s_beat_t     sbeat_q[$];
    m_beat_t     exp_q[$];   // popped by the monitor
    int          exp_total = 0;
    int          m_count   = 0;
    int          s_count   = 0;
    logic [31:0] lfsr      = LFSR_SEED;

    wconv_top u_wconv_top (
        .clk_sys   (clk_sys),
        .rst_n     (rst_n),
        .split_en  (split_en),
        .split_cmd (split_cmd),
        .s_valid   (s_valid),
        .s_beat    (s_beat),
        .s_ready   (s_ready),
        .m_valid   (m_valid),
        .m_beat    (m_beat),
        .m_ready   (m_ready)
    );

    initial begin
        clk_sys = 1'b0;
        forever #4 clk_sys = ~clk_sys; // 8 ns period
    end

    // ------------------------------------------------------------
    // random bits and error helpers
    // ------------------------------------------------------------
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]}; // taps 32 22 2 1
    endfunction

    function automatic logic take_bit();
        lfsr = lfsr_next(lfsr);
        return lfsr[0];
    endfunction

    task automatic finish_with_failure();
        $display("sim failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic report_problem(input string msg);
        $display("ERROR at %0t: %s", $time, msg);
        finish_with_failure();
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s is %b, expected %b", $time, what, got, exp);
            finish_with_failure();
        end
    endtask

    task automatic check_beat(input m_beat_t got, input m_beat_t exp, input int idx);
        if (got.data !== exp.data) begin
            $display("CHECK FAILED at %0t: beat %0d data %h, expected %h",
                     $time, idx, got.data, exp.data);
            finish_with_failure();
        end
        if (got.strb !== exp.strb) begin
            $display("CHECK FAILED at %0t: beat %0d strb %h, expected %h",
                     $time, idx, got.strb, exp.strb);
            finish_with_failure();
        end
        if (got.last !== exp.last) begin
            $display("CHECK FAILED at %0t: beat %0d last %b, expected %b",
                     $time, idx, got.last, exp.last);
            finish_with_failure();
        end
    endtask

    task automatic check_count(input int beats_got, input int beats_exp,
                               input int slaves_got, input int slaves_exp);
        if (beats_got != beats_exp || slaves_got != slaves_exp) begin
            $display("CHECK FAILED at %0t: %0d master and %0d slave beats, expected %0d and %0d",
                     $time, beats_got, slaves_got, beats_exp, slaves_exp);
            finish_with_failure();
        end
    endtask

    // ------------------------------------------------------------
    // stimulus file and slave driver
    // ------------------------------------------------------------
    task automatic load_stimulus();
        int                fd;
        int                code;
        logic [7:0]        tag;
        logic [63:0]       fld [4];
        logic [8*200-1:0]  rest;
        split_cmd_t        c;
        s_beat_t           s;
        m_beat_t           e;
        fd = $fopen("wconv_stimulus.txt", "r");
        if (fd == 0) begin
            report_problem("cannot open wconv_stimulus.txt");
        end
        while (!$feof(fd)) begin
            code = $fscanf(fd, "%s", tag);
            if (code != 1) break;
            if (tag == "#") begin
                code = $fgets(rest, fd); // comment line
            end else if (tag == "C") begin
                code = $fscanf(fd, "%h %h %h %h", fld[0], fld[1], fld[2], fld[3]);
                c.reqsize = fld[0][2:0];
                c.size    = fld[1][2:0];
                c.len     = fld[2][7:0];
                c.offset  = fld[3][7:0];
                cmd_q.push_back(c);
            end else if (tag == "S") begin
                code = $fscanf(fd, "%h %h", fld[0], fld[1]);
                s.data = fld[0];
                s.strb = fld[1][7:0];
                sbeat_q.push_back(s);
            end else if (tag == "E") begin
                code = $fscanf(fd, "%h %h %h", fld[0], fld[1], fld[2]);
                e.data = fld[0][31:0];
                e.strb = fld[1][3:0];
                e.last = fld[2][0];
                exp_q.push_back(e);
            end else begin
                report_problem("unknown line tag in the stimulus file");
            end
        end
        $fclose(fd);
        exp_total = exp_q.size();
    endtask

    // caller sits just after a rising edge
    task automatic send_slave_beat(input s_beat_t beat);
        int waited = 0;
        s_valid = 1'b1;
        s_beat  = beat;
        @(negedge clk_sys);
        while (s_ready !== 1'b1) begin
            waited++;
            if (waited > TIMEOUT_CYCLES) begin
                report_problem("timeout waiting for s_ready on a slave beat");
            end
            @(negedge clk_sys);
        end
        @(posedge clk_sys); // beat taken here
        #1;
        s_valid = 1'b0;
    endtask

    // random back-pressure, mostly ready
    initial begin
        m_ready = 1'b0;
        @(posedge rst_n);
        forever begin
            @(posedge clk_sys);
            #1;
            m_ready = take_bit();
            if (!m_ready) m_ready = take_bit();
        end
    end

    // slave side handshakes seen at the DUT
    always @(negedge clk_sys) begin
        if (rst_n && s_valid && s_ready) begin
            s_count++;
        end
    end

    // master side monitor
    always @(negedge clk_sys) begin
        if (rst_n && m_valid && m_ready) begin
            if (exp_q.size() == 0) begin
                report_problem("master side sent a beat that was not expected");
            end else begin
                check_beat(m_beat, exp_q.pop_front(), m_count);
                m_count++;
            end
        end
    end

    // ------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------
    initial begin
        int gaps;
        int waited;
        rst_n     = 1'b0;
        split_en  = 1'b0;
        split_cmd = '0;
        s_valid   = 1'b0;
        s_beat    = '0;
        load_stimulus();
        if (cmd_q.size() > 4) begin
            report_problem("stimulus file holds more than four commands");
        end

        repeat (5) begin
            @(negedge clk_sys);
            check_bit(m_valid, 1'b0, "m_valid in reset");
            check_bit(s_ready, 1'b0, "s_ready in reset");
        end
        @(posedge clk_sys);
        #1;
        rst_n = 1'b1;
        @(negedge clk_sys);
        check_bit(m_valid, 1'b0, "m_valid after reset");
        check_bit(s_ready, 1'b0, "s_ready after reset");
        @(posedge clk_sys);
        #1;

        foreach (cmd_q[i]) begin // all commands up front
            split_en  = 1'b1;
            split_cmd = cmd_q[i];
            @(posedge clk_sys);
            #1;
        end
        split_en = 1'b0;

        foreach (sbeat_q[i]) begin
            gaps = take_bit() ? 2 : 0; // zero to three idle cycles
            if (take_bit()) gaps = gaps + 1;
            repeat (gaps) begin
                @(posedge clk_sys);
                #1;
            end
            send_slave_beat(sbeat_q[i]);
        end

        waited = 0;
        while (exp_q.size() != 0) begin
            @(posedge clk_sys);
            waited++;
            if (waited > TIMEOUT_CYCLES) begin
                report_problem("timeout with master beats still outstanding");
            end
        end

        repeat (TIMEOUT_CYCLES) begin // nothing more may come out
            @(negedge clk_sys);
            check_bit(m_valid, 1'b0, "m_valid after the last beat");
        end
        check_count(m_count, exp_total, s_count, sbeat_q.size());
        $display("sim passed");
        $finish;
    end

endmodule

//--- wconv_stimulus.txt
# C reqsize size len offset, S slave data strb, E master data strb last
# all fields hex, each tag is consumed in file order
C 2 1 03 00
C 3 0 01 04
C 1 2 05 02
C 2 1 02 08
# slave beats
S 0123456789abcdef ff
S fedcba9876543210 ff
S cafef00d5555aaaa f3
S 13579bdf2468ace0 3c
S a5a5a5a55a5a5a5a 96
S deadbeef0badf00d c1
S 7777666655554444 7e
S 9999888800001111 0f
# expected master beats
E 89abcdef f 0
E 01234567 f 0
E 76543210 f 0
E fedcba98 f 1
E cafef00d f 0
E 13579bdf 3 1
E 5a5a5a5a 6 0
E a5a5a5a5 9 0
E a5a5a5a5 9 0
E 5a5a5a5a 6 0
E 0badf00d 1 0
E deadbeef c 1
E 55554444 e 0
E 77776666 7 0
E 00001111 f 1

//--- run_sim.sh
#!/bin/sh
# build and run the width converter testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f verilog.f --top-module tb_wconv -o tb_wconv
./obj_dir/tb_wconv | tee sim.log

if grep -qx "sim passed" sim.log; then
    exit 0
fi
exit 1

//--- verilog.f
+incdir+.
wconv_pkg.sv
sync_fifo.sv
split_ctrl.sv
lane_mux.sv
wconv_top.sv
tb_wconv.sv
